// File: build.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/inst_buffer.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/cpu.sv
verification/tb_clock_gen.sv
verification/tb_cpu.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // active high and dropped just after an edge
    initial begin
        reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int DEPTH    = `INST_BUF_DEPTH;
    localparam int WATCHDOG = PROG_LEN * 8 + 200;

    logic                  clk;
    logic                  reset_n;
    logic                  inst_valid;
    inst_word_t            inst_data;
    logic                  inst_credit;
    logic [`WORD_SIZE-1:0] output_port;
    logic                  output_valid;
    logic [`WORD_SIZE-1:0] num_inst;
    logic                  is_halted;

    inst_word_t            prog [PROG_LEN];
    logic [`WORD_SIZE-1:0] wwd_queue [$];    // expected output_port values in order
    int                    expected_count;
    int                    credits;
    int                    returned;
    int                    errors;
    int                    checks;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) i_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpu i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .inst_valid   (inst_valid),
        .inst_data    (inst_data),
        .inst_credit  (inst_credit),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program and reference model

    function automatic inst_word_t special_inst(input logic [5:0] funct, input logic [1:0] src);
        inst_word_t w;
        w          = '0;
        w.r.opcode = `OP_RTYPE;
        w.r.rs     = src;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic inst_word_t random_inst();
        inst_word_t w;
        int         kind;
        logic [3:0] op;
        w    = 16'($urandom);
        kind = $urandom_range(0, 9);
        op   = 4'($urandom_range(0, 11));
        if (op >= 4'd4) op = op + 4'd3;    // skip the immediate opcodes
        case (kind)
            0, 1, 2, 3, 4: begin
                w.r.opcode = `OP_RTYPE;
                w.r.funct  = 6'($urandom_range(0, 7));
            end
            5: w.i.opcode = `OP_ADI;
            6: w.i.opcode = `OP_ORI;
            7: w.i.opcode = `OP_LHI;
            8: w = special_inst(`FUNC_WWD, w.r.rs);
            default: w.r.opcode = op;
        endcase
        return w;
    endfunction

    task automatic build_program();
        for (int n = 0; n < PROG_LEN - 8; n++) begin
            prog[n] = random_inst();
        end
        for (int r = 0; r < 4; r++) begin
            prog[PROG_LEN - 8 + r] = special_inst(`FUNC_WWD, 2'(r));
        end
        prog[PROG_LEN - 4] = special_inst(`FUNC_HLT, 2'd0);
        for (int n = PROG_LEN - 3; n < PROG_LEN; n++) begin
            prog[n] = special_inst(`FUNC_WWD, 2'(n));    // must never retire
        end
    endtask

    function automatic logic [15:0] alu_ref(input logic [5:0] funct, input logic [15:0] a,
                                            input logic [15:0] b);
        case (funct)
            `FUNC_ADD: return a + b;
            `FUNC_SUB: return a + ~b + 16'd1;
            `FUNC_AND: return a & b;
            `FUNC_ORR: return a | b;
            `FUNC_NOT: return ~a;
            `FUNC_TCP: return 16'd0 - a;
            `FUNC_SHL: return {a[14:0], 1'b0};
            default:   return 16'($signed(a) >>> 1);
        endcase
    endfunction

    task automatic run_model();
        logic [15:0] regs [4] = '{default: '0};
        inst_word_t  w;
        expected_count = 0;
        foreach (prog[n]) begin
            w = prog[n];
            expected_count++;
            case (w.r.opcode)
                `OP_RTYPE: begin
                    if (w.r.funct == `FUNC_HLT) return;
                    if (w.r.funct == `FUNC_WWD) wwd_queue.push_back(regs[w.r.rs]);
                    else if (w.r.funct <= `FUNC_SHR)
                        regs[w.r.rd] = alu_ref(w.r.funct, regs[w.r.rs], regs[w.r.rt]);
                end
                `OP_ADI: regs[w.i.rt] = regs[w.i.rs] + {{8{w.i.imm[7]}}, w.i.imm};
                `OP_ORI: regs[w.i.rt] = regs[w.i.rs] | {8'h00, w.i.imm};
                `OP_LHI: regs[w.i.rt] = {w.i.imm, 8'h00};
                default: ;    // no-op, still counted
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driver and monitor

    task automatic drive_program();
        int next_idx = 0;
        forever begin
            @(posedge clk);
            #1;
            if (inst_credit === 1'b1) begin
                returned++;
                if (credits >= DEPTH) report_failure("credit returned while all were held");
                else credits++;
            end
            inst_valid = 1'b0;
            if (next_idx < PROG_LEN && credits > 0 && $urandom_range(0, 3) != 0) begin
                inst_valid = 1'b1;
                inst_data  = prog[next_idx];
                next_idx++;
                credits--;
            end
        end
    endtask

    task automatic watch_outputs();
        logic halted_seen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (halted_seen && is_halted !== 1'b1) report_failure("is_halted fell without reset");
            if (is_halted === 1'b1) begin
                halted_seen = 1'b1;
                if (inst_credit !== 1'b0) report_failure("inst_credit pulsed after halt");
            end
            if (output_valid === 1'b1) begin
                if (wwd_queue.size() == 0)
                    report_failure("output_valid with no WWD left to retire");
                else check_value("output_port", output_port, wwd_queue.pop_front());
            end
        end
    endtask

    task automatic check_reset_state();
        check_value("inst_credit", inst_credit, 0);
        check_value("output_valid", output_valid, 0);
        check_value("is_halted", is_halted, 0);
        check_value("num_inst", num_inst, 0);
        check_value("output_port", output_port, 0);
    endtask

    initial begin
        int seed;
        int first_draw;
        inst_valid = 1'b0;
        inst_data  = '0;
        credits    = DEPTH;
        returned   = 0;
        errors     = 0;
        checks     = 0;
        seed       = 32'h352e;
        first_draw = $urandom(seed);
        build_program();
        run_model();

        repeat (2) @(posedge clk);
        while (reset_n === 1'b1) begin
            #2;
            check_reset_state();
            @(posedge clk);
        end
        #2;
        check_reset_state();    // first cycle out of reset

        fork
            drive_program();
            watch_outputs();
        join_none

        while (is_halted !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        repeat (12) @(posedge clk);    // let trailing junk show up if it leaks
        #2;
        check_value("num_inst", num_inst, expected_count);
        check_value("wwd_queue size", wwd_queue.size(), 0);
        // at most the two younger instructions in decode and execute got popped
        if (returned < expected_count || returned > expected_count + 2)
            report_failure($sformatf("%0d credits returned for %0d retired", returned,
                                     expected_count));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the CPU did not halt within %0d cycles", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module alu (
    input  wire [`WORD_SIZE-1:0]     a,
    input  wire [`WORD_SIZE-1:0]     b,
    input  wire [`ALU_FUNC_SIZE-1:0] func,
    output logic [`WORD_SIZE-1:0]    result
);

    always_comb begin
        case (func)
            `ALU_ADD: result = a + b;
            `ALU_SUB: result = a - b;
            `ALU_AND: result = a & b;
            `ALU_ORR: result = a | b;
            `ALU_NOT: result = ~a;
            `ALU_TCP: result = -a;
            `ALU_SHL: result = a << 1;
            `ALU_SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};    // keeps sign
            `ALU_IOR: result = a | b;
            `ALU_LHI: result = b << 8;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module control_unit (
    input  wire cpu_pkg::inst_word_t      inst,
    output logic [`ALU_FUNC_SIZE-1:0]     alu_func,
    output logic                          alu_src_imm,
    output logic                          imm_zero_ext,
    output logic                          reg_write,
    output logic                          dest_is_rd,
    output logic                          wwd,
    output logic                          halt
);

    always_comb begin
        alu_func     = `ALU_ADD;
        alu_src_imm  = 1'b0;
        imm_zero_ext = 1'b0;
        reg_write    = 1'b0;
        dest_is_rd   = 1'b0;
        wwd          = 1'b0;
        halt         = 1'b0;

        case (inst.r.opcode)
            `OP_RTYPE: begin
                dest_is_rd = 1'b1;
                reg_write  = 1'b1;
                case (inst.r.funct)
                    `FUNC_ADD: alu_func = `ALU_ADD;
                    `FUNC_SUB: alu_func = `ALU_SUB;
                    `FUNC_AND: alu_func = `ALU_AND;
                    `FUNC_ORR: alu_func = `ALU_ORR;
                    `FUNC_NOT: alu_func = `ALU_NOT;
                    `FUNC_TCP: alu_func = `ALU_TCP;
                    `FUNC_SHL: alu_func = `ALU_SHL;
                    `FUNC_SHR: alu_func = `ALU_SHR;
                    `FUNC_WWD: begin
                        reg_write = 1'b0;
                        wwd       = 1'b1;
                    end
                    `FUNC_HLT: begin
                        reg_write = 1'b0;
                        halt      = 1'b1;
                    end
                    default: reg_write = 1'b0;    // unknown funct is a no-op
                endcase
            end
            `OP_ADI: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            `OP_ORI: begin
                alu_func     = `ALU_IOR;
                alu_src_imm  = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write    = 1'b1;
            end
            `OP_LHI: begin
                alu_func    = `ALU_LHI;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      inst_valid,
    input  wire cpu_pkg::inst_word_t inst_data,
    output logic                     inst_credit,
    output logic [`WORD_SIZE-1:0]    output_port,
    output logic                     output_valid,
    output logic [`WORD_SIZE-1:0]    num_inst,
    output logic                     is_halted
);
    import cpu_pkg::*;

    logic       buf_pop;
    inst_word_t buf_data;
    logic       halt_now;

    // decode
    inst_word_t                dec_inst;
    logic                      dec_valid;
    logic [`ALU_FUNC_SIZE-1:0] dec_alu_func;
    logic                      dec_alu_src_imm, dec_imm_zero_ext, dec_reg_write;
    logic                      dec_dest_is_rd, dec_wwd, dec_halt;
    logic [`WORD_SIZE-1:0]     dec_rdata1, dec_rdata2, dec_imm;

    // execute
    logic                      ex_valid, ex_reg_write, ex_wwd, ex_halt;
    logic [`ALU_FUNC_SIZE-1:0] ex_alu_func;
    logic                      ex_alu_src_imm;
    logic [`WORD_SIZE-1:0]     ex_rdata1, ex_rdata2, ex_imm;
    logic [`REG_ADDR_SIZE-1:0] ex_rs, ex_rt, ex_dest;
    logic [`WORD_SIZE-1:0]     fwd_a, fwd_b, alu_b, alu_result;

    // writeback
    logic                      wb_valid, wb_reg_write, wb_wwd, wb_halt;
    logic [`WORD_SIZE-1:0]     wb_result, wb_wwd_value;
    logic [`REG_ADDR_SIZE-1:0] wb_dest;

    assign halt_now = wb_valid & wb_halt;

    inst_buffer i_inst_buffer (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (inst_valid),
        .push_data (inst_data),
        .halted    (is_halted | halt_now),    // no pop at the halting edge
        .pop       (buf_pop),
        .pop_data  (buf_data),
        .credit    (inst_credit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // decode

    always_ff @(posedge clk) begin
        if (reset_n) dec_valid <= 1'b0;
        else         dec_valid <= buf_pop;
    end

    always_ff @(posedge clk) begin
        if (buf_pop) dec_inst <= buf_data;
    end

    control_unit i_control_unit (
        .inst         (dec_inst),
        .alu_func     (dec_alu_func),
        .alu_src_imm  (dec_alu_src_imm),
        .imm_zero_ext (dec_imm_zero_ext),
        .reg_write    (dec_reg_write),
        .dest_is_rd   (dec_dest_is_rd),
        .wwd          (dec_wwd),
        .halt         (dec_halt)
    );

    register_file i_register_file (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_addr1 (dec_inst.r.rs),
        .read_addr2 (dec_inst.r.rt),
        .write_addr (wb_dest),
        .write_en   (wb_valid & wb_reg_write),
        .write_data (wb_result),
        .read_data1 (dec_rdata1),
        .read_data2 (dec_rdata2)
    );

    // zero extension only for ori
    assign dec_imm = dec_imm_zero_ext ? {8'h00, dec_inst.i.imm}
                                      : {{8{dec_inst.i.imm[7]}}, dec_inst.i.imm};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_wwd       <= 1'b0;
            ex_halt      <= 1'b0;
        end else begin
            ex_valid     <= dec_valid & ~halt_now;
            ex_reg_write <= dec_reg_write;
            ex_wwd       <= dec_wwd;
            ex_halt      <= dec_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_rdata1      <= dec_rdata1;
        ex_rdata2      <= dec_rdata2;
        ex_imm         <= dec_imm;
        ex_alu_func    <= dec_alu_func;
        ex_alu_src_imm <= dec_alu_src_imm;
        ex_rs          <= dec_inst.r.rs;
        ex_rt          <= dec_inst.r.rt;
        ex_dest        <= dec_dest_is_rd ? dec_inst.r.rd : dec_inst.r.rt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // execute

    // forward from writeback to the next instruction
    assign fwd_a = (wb_valid && wb_reg_write && wb_dest == ex_rs) ? wb_result : ex_rdata1;
    assign fwd_b = (wb_valid && wb_reg_write && wb_dest == ex_rt) ? wb_result : ex_rdata2;
    assign alu_b = ex_alu_src_imm ? ex_imm : fwd_b;

    alu i_alu (
        .a      (fwd_a),
        .b      (alu_b),
        .func   (ex_alu_func),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_wwd       <= 1'b0;
            wb_halt      <= 1'b0;
        end else begin
            wb_valid     <= ex_valid & ~halt_now;
            wb_reg_write <= ex_reg_write;
            wb_wwd       <= ex_wwd;
            wb_halt      <= ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_result    <= alu_result;
        wb_dest      <= ex_dest;
        wb_wwd_value <= fwd_a;
    end

    ////////////////////////////////////////////////////////////////////////////
    // writeback

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst     <= '0;
            output_port  <= '0;
            output_valid <= 1'b0;
            is_halted    <= 1'b0;
        end else begin
            output_valid <= wb_valid & wb_wwd;
            if (wb_valid) num_inst <= num_inst + 1'b1;
            if (wb_valid && wb_wwd) output_port <= wb_wwd_value;
            if (halt_now) is_halted <= 1'b1;    // sticky until reset
        end
    end

    assert property (@(posedge clk) disable iff (reset_n) is_halted |=> is_halted);

endmodule

`default_nettype wire

// File: verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_SIZE      16
`define REG_COUNT      4
`define REG_ADDR_SIZE  2
`define INST_BUF_DEPTH 4

// opcodes
`define OP_RTYPE 4'd15
`define OP_ADI   4'd4
`define OP_ORI   4'd5
`define OP_LHI   4'd6

// r-type function codes
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

// alu selector
`define ALU_FUNC_SIZE 4
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_ORR 4'd3
`define ALU_NOT 4'd4
`define ALU_TCP 4'd5
`define ALU_SHL 4'd6
`define ALU_SHR 4'd7
`define ALU_IOR 4'd8    // immediate or
`define ALU_LHI 4'd9    // upper load

`endif

// File: verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef struct packed {
        logic [3:0]                opcode;
        logic [`REG_ADDR_SIZE-1:0] rs;
        logic [`REG_ADDR_SIZE-1:0] rt;
        logic [`REG_ADDR_SIZE-1:0] rd;
        logic [5:0]                funct;
    } inst_r_t;

    typedef struct packed {
        logic [3:0]                opcode;
        logic [`REG_ADDR_SIZE-1:0] rs;
        logic [`REG_ADDR_SIZE-1:0] rt;
        logic [7:0]                imm;
    } inst_i_t;

    // one word in r-type or immediate layout
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_t;

endpackage

`default_nettype wire

// File: verilog/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module inst_buffer (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 push,
    input  wire cpu_pkg::inst_word_t push_data,
    input  wire                 halted,
    output logic                pop,
    output cpu_pkg::inst_word_t pop_data,
    output logic                credit
);
    import cpu_pkg::*;

    localparam int unsigned DEPTH = `INST_BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    inst_word_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign pop      = (count != '0) && !halted;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;    // one credit back per pop
        end
    end

    // sender must hold a credit for every push
    assert property (@(posedge clk) disable iff (reset_n)
        !(push && count == (PTR_W + 1)'(DEPTH)));

    assert property (@(posedge clk) disable iff (reset_n)
        count <= (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module register_file (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire [`REG_ADDR_SIZE-1:0] read_addr1,
    input  wire [`REG_ADDR_SIZE-1:0] read_addr2,
    input  wire [`REG_ADDR_SIZE-1:0] write_addr,
    input  wire                      write_en,
    input  wire [`WORD_SIZE-1:0]     write_data,
    output logic [`WORD_SIZE-1:0]    read_data1,
    output logic [`WORD_SIZE-1:0]    read_data2
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // write-through on a same-cycle write
    assign read_data1 = (write_en && write_addr == read_addr1) ? write_data
                                                               : regs[read_addr1];
    assign read_data2 = (write_en && write_addr == read_addr2) ? write_data
                                                               : regs[read_addr2];

endmodule

`default_nettype wire
